// ==== hdl/ternary_alu_params.svh ====
// Ternary ALU constants: trit codes, word and opcode sizes, opcode encodings
`ifndef TERNARY_ALU_PARAMS_SVH
`define TERNARY_ALU_PARAMS_SVH

// Trit codes, two bits each
// Code 2'b10 is unused and reads as zero wherever a value is taken
`define TRIT_NEG  2'b11
`define TRIT_ZERO 2'b00
`define TRIT_POS  2'b01

// Sizes
`define TRIT_BITS    2
`define WORD_TRITS   9
`define OPCODE_TRITS 3

// Opcodes, high trit first
// Logic group has a zero high trit
`define OP_NOT 6'b00_00_01
`define OP_AND 6'b00_01_11
`define OP_OR  6'b00_01_00
`define OP_XOR 6'b00_01_01

// Arithmetic and compare group has a plus-one high trit
`define OP_ADD 6'b01_11_11
`define OP_SUB 6'b01_11_00
`define OP_LT  6'b01_00_11
`define OP_EQ  6'b01_00_00

`endif

// ==== hdl/ternary_alu_pkg.sv ====
// Shared types of the ternary ALU: trit, word, opcode, slice controls and chain links
`include "ternary_alu_params.svh"

package ternary_alu_pkg;

    // One balanced trit in two-bit code
    typedef logic [`TRIT_BITS-1:0] trit_t;

    // Nine-trit operand or result
    typedef logic [`WORD_TRITS*`TRIT_BITS-1:0] word_t;

    // Three-trit opcode
    typedef logic [`OPCODE_TRITS*`TRIT_BITS-1:0] opcode_t;

    // Carry trit from a lower slice into the next higher one
    typedef logic [`TRIT_BITS-1:0] carry_link_t;

    // Per-trit operation for every slice
    typedef enum logic [2:0] {
        SLICE_NOT,
        SLICE_AND,
        SLICE_OR,
        SLICE_XOR,
        SLICE_ADD,
        SLICE_SUB,
        SLICE_PASS
    } slice_op_e;

    // What the result stage loads
    typedef enum logic [1:0] {
        KIND_WORD,
        KIND_LT,
        KIND_EQ
    } result_kind_e;

    // Compare state passed from a higher slice down to a lower one
    // lt set once a higher trit decided input1 < input2
    // eq still high while all higher trits matched
    typedef struct packed {
        logic lt;
        logic eq;
    } cmp_link_t;

endpackage

// ==== hdl/alu_opcode_decoder.sv ====
// Opcode decoder: turns a three-trit opcode into the slice operation and result kind
`include "ternary_alu_params.svh"

module alu_opcode_decoder (
    input  ternary_alu_pkg::opcode_t      opcode,
    output ternary_alu_pkg::slice_op_e    slice_op,
    output ternary_alu_pkg::result_kind_e result_kind
);
    import ternary_alu_pkg::*;

    always_comb begin
        // Unknown opcodes pass input1 through as a word
        slice_op    = SLICE_PASS;
        result_kind = KIND_WORD;

        case (opcode)
            `OP_NOT: begin
                slice_op = SLICE_NOT;
            end
            `OP_AND: begin
                slice_op = SLICE_AND;
            end
            `OP_OR: begin
                slice_op = SLICE_OR;
            end
            `OP_XOR: begin
                slice_op = SLICE_XOR;
            end
            `OP_ADD: begin
                slice_op = SLICE_ADD;
            end
            `OP_SUB: begin
                // Slices negate input2 and reuse the adder
                slice_op = SLICE_SUB;
            end
            // Compares only need the chain, slice word is ignored
            `OP_LT: begin
                result_kind = KIND_LT;
            end
            `OP_EQ: begin
                result_kind = KIND_EQ;
            end
            default: begin
                slice_op    = SLICE_PASS;
                result_kind = KIND_WORD;
            end
        endcase
    end

endmodule

// ==== hdl/trit_slice.sv ====
// One trit position of the ALU: logic ops, ripple adder step and compare chain step
`include "ternary_alu_params.svh"

module trit_slice (
    input  ternary_alu_pkg::trit_t       a,
    input  ternary_alu_pkg::trit_t       b,
    input  ternary_alu_pkg::slice_op_e   slice_op,
    input  ternary_alu_pkg::carry_link_t carry_in,
    output ternary_alu_pkg::carry_link_t carry_out,
    input  ternary_alu_pkg::cmp_link_t   cmp_in,
    output ternary_alu_pkg::cmp_link_t   cmp_out,
    output ternary_alu_pkg::trit_t       result
);
    import ternary_alu_pkg::*;

    // Unused code 10 reads as zero
    function automatic trit_t clean_trit(input trit_t t);
        return (t == 2'b10) ? `TRIT_ZERO : t;
    endfunction

    // Swap plus and minus, zero stays
    function automatic trit_t neg_trit(input trit_t t);
        case (t)
            `TRIT_NEG: return `TRIT_POS;
            `TRIT_POS: return `TRIT_NEG;
            default:   return `TRIT_ZERO;
        endcase
    endfunction

    // Cleaned operands
    trit_t a_c;
    trit_t b_c;
    trit_t addend;

    // Cleaned codes are two's complement, so signed views are direct
    logic signed [1:0] a_v;
    logic signed [1:0] b_v;
    logic signed [1:0] d_v;
    logic signed [1:0] c_v;

    // Wide sums, -2..2 for the pair and -3..3 for the full add
    logic signed [2:0] pair_sum;
    logic signed [2:0] pair_digit;
    logic signed [2:0] total;
    logic signed [2:0] sum_digit;

    // Per-operation trits
    trit_t neg_r;
    trit_t min_r;
    trit_t max_r;
    trit_t xor_r;
    trit_t sum_r;

    assign a_c    = clean_trit(a);
    assign b_c    = clean_trit(b);
    // SUB adds the negated second operand
    assign addend = (slice_op == SLICE_SUB) ? neg_trit(b_c) : b_c;

    assign a_v = $signed(a_c);
    assign b_v = $signed(b_c);
    assign d_v = $signed(addend);
    assign c_v = $signed(carry_in);

    // Trit-wise logic
    assign neg_r = neg_trit(a_c);
    assign min_r = (a_v < b_v) ? a_c : b_c;
    assign max_r = (a_v > b_v) ? a_c : b_c;

    always_comb begin
        // Modulo-3 sum, 2 wraps to -1 and -2 wraps to +1
        pair_sum = a_v + b_v;
        if (pair_sum > 3'sd1) begin
            pair_digit = pair_sum - 3'sd3;
        end else if (pair_sum < -3'sd1) begin
            pair_digit = pair_sum + 3'sd3;
        end else begin
            pair_digit = pair_sum;
        end
        xor_r = trit_t'(pair_digit[1:0]);
    end

    always_comb begin
        // Full add of three trits, split into a balanced digit and carry
        total = a_v + d_v + c_v;
        if (total > 3'sd1) begin
            sum_digit = total - 3'sd3;
            carry_out = `TRIT_POS;
        end else if (total < -3'sd1) begin
            sum_digit = total + 3'sd3;
            carry_out = `TRIT_NEG;
        end else begin
            sum_digit = total;
            carry_out = `TRIT_ZERO;
        end
        sum_r = trit_t'(sum_digit[1:0]);
    end

    // Compare step, a decision from a higher trit is kept
    assign cmp_out.lt = cmp_in.lt | (cmp_in.eq & (a_v < b_v));
    assign cmp_out.eq = cmp_in.eq & (a_v == b_v);

    always_comb begin
        case (slice_op)
            SLICE_NOT: result = neg_r;
            SLICE_AND: result = min_r;
            SLICE_OR:  result = max_r;
            SLICE_XOR: result = xor_r;
            SLICE_ADD: result = sum_r;
            SLICE_SUB: result = sum_r;
            // Pass keeps the raw code, 10 included
            default:   result = a;
        endcase
    end

endmodule

// ==== hdl/alu_result_stage.sv ====
// Result register: picks the slice word or a compare flag word and holds it on alu_out
`include "ternary_alu_params.svh"

module alu_result_stage (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          alu_enable,
    input  ternary_alu_pkg::result_kind_e result_kind,
    input  ternary_alu_pkg::word_t        slice_word,
    input  ternary_alu_pkg::cmp_link_t    cmp_final,
    output ternary_alu_pkg::word_t        alu_out
);
    import ternary_alu_pkg::*;

    // Flag chosen by the compare kind
    logic  flag;
    // Flag as a word, only trit 0 can be nonzero
    word_t flag_word;
    // Value loaded on the next enabled edge
    word_t next_word;

    always_comb begin
        case (result_kind)
            KIND_LT: flag = cmp_final.lt;
            KIND_EQ: flag = cmp_final.eq;
            default: flag = 1'b0;
        endcase
    end

    always_comb begin
        flag_word = '0;
        flag_word[`TRIT_BITS-1:0] = flag ? `TRIT_POS : `TRIT_ZERO;
    end

    // Compare kinds take the flag word, everything else the slice word
    assign next_word = (result_kind == KIND_WORD) ? slice_word : flag_word;

    // One register stage
    // Enable low holds the last result
    always_ff @(posedge clock) begin
        if (reset) begin
            alu_out <= '0;
        end else if (alu_enable) begin
            alu_out <= next_word;
        end
    end

endmodule

// ==== hdl/ternary_alu.sv ====
// Ternary ALU top: opcode decoder, nine trit slices with carry and compare chains, result register
`include "ternary_alu_params.svh"

module ternary_alu (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     alu_enable,
    input  ternary_alu_pkg::opcode_t opcode,
    input  ternary_alu_pkg::word_t   input1,
    input  ternary_alu_pkg::word_t   input2,
    output ternary_alu_pkg::word_t   alu_out
);
    import ternary_alu_pkg::*;

    // Decoded controls
    slice_op_e    slice_op;
    result_kind_e result_kind;

    // Carry ripples upward, carry[i] enters slice i
    // carry[WORD_TRITS] leaves trit 8 and is dropped, so sums wrap mod 3^9
    carry_link_t carry [0:`WORD_TRITS];

    // Compare runs downward, cmp[i+1] enters slice i
    cmp_link_t cmp [0:`WORD_TRITS];

    // Result trits packed back into a word
    word_t slice_word;

    alu_opcode_decoder u_decoder (
        .opcode      (opcode),
        .slice_op    (slice_op),
        .result_kind (result_kind)
    );

    // Chain ends, no carry into trit 0
    assign carry[0] = `TRIT_ZERO;
    // Above trit 8 nothing has been decided yet
    assign cmp[`WORD_TRITS] = '{lt: 1'b0, eq: 1'b1};

    for (genvar i = 0; i < `WORD_TRITS; i++) begin : g_slice
        trit_slice u_slice (
            .a         (input1[i*`TRIT_BITS +: `TRIT_BITS]),
            .b         (input2[i*`TRIT_BITS +: `TRIT_BITS]),
            .slice_op  (slice_op),
            .carry_in  (carry[i]),
            .carry_out (carry[i+1]),
            .cmp_in    (cmp[i+1]),
            .cmp_out   (cmp[i]),
            .result    (slice_word[i*`TRIT_BITS +: `TRIT_BITS])
        );
    end

    // Compare link out of slice 0 holds the whole-word decision
    alu_result_stage u_result (
        .clock       (clock),
        .reset       (reset),
        .alu_enable  (alu_enable),
        .result_kind (result_kind),
        .slice_word  (slice_word),
        .cmp_final   (cmp[0]),
        .alu_out     (alu_out)
    );

endmodule

// ==== tests/ternary_alu_props.sv ====
// Ternary ALU checker: integer reference model and assertions on alu_out
`include "ternary_alu_params.svh"

module ternary_alu_props (
    input logic                     clock,
    input logic                     reset,
    input logic                     alu_enable,
    input ternary_alu_pkg::opcode_t opcode,
    input ternary_alu_pkg::word_t   input1,
    input ternary_alu_pkg::word_t   input2,
    input ternary_alu_pkg::word_t   alu_out
);
    timeunit 1ns;
    timeprecision 100ps;
    import ternary_alu_pkg::*;

    // Model state, valid once a reset was seen
    logic  model_valid = 1'b0;
    word_t expected_out;
    // Read by the testbench
    int    check_count = 0;
    int    error_count = 0;

    // Code 10 counts as zero
    function automatic int trit_value(input trit_t t);
        case (t)
            `TRIT_POS: return 1;
            `TRIT_NEG: return -1;
            default:   return 0;
        endcase
    endfunction

    function automatic trit_t trit_code(input int v);
        if (v > 0) return `TRIT_POS;
        if (v < 0) return `TRIT_NEG;
        return `TRIT_ZERO;
    endfunction

    // Sum of trit times 3^i
    function automatic int word_value(input word_t w);
        int total;
        int weight;
        total  = 0;
        weight = 1;
        for (int i = 0; i < `WORD_TRITS; i++) begin
            total  += trit_value(w[i*`TRIT_BITS +: `TRIT_BITS]) * weight;
            weight *= 3;
        end
        return total;
    endfunction

    // Wraps into -9841..9841, then splits into balanced digits
    function automatic word_t value_word(input int value);
        int    v;
        int    r;
        word_t w;
        v = value % 19683;
        if (v > 9841) v -= 19683;
        if (v < -9841) v += 19683;
        w = '0;
        for (int i = 0; i < `WORD_TRITS; i++) begin
            r = v % 3;
            if (r > 1) r -= 3;
            if (r < -1) r += 3;
            w[i*`TRIT_BITS +: `TRIT_BITS] = trit_code(r);
            v = (v - r) / 3;
        end
        return w;
    endfunction

    // NOT, AND, OR and XOR on trit values
    function automatic word_t tritwise(input opcode_t op, input word_t a, input word_t b);
        int    x;
        int    y;
        int    r;
        word_t w;
        w = '0;
        for (int i = 0; i < `WORD_TRITS; i++) begin
            x = trit_value(a[i*`TRIT_BITS +: `TRIT_BITS]);
            y = trit_value(b[i*`TRIT_BITS +: `TRIT_BITS]);
            case (op)
                `OP_NOT: r = -x;
                `OP_AND: r = (x < y) ? x : y;
                `OP_OR:  r = (x > y) ? x : y;
                default: begin
                    // Balanced sum modulo 3
                    r = x + y;
                    if (r > 1) r -= 3;
                    else if (r < -1) r += 3;
                end
            endcase
            w[i*`TRIT_BITS +: `TRIT_BITS] = trit_code(r);
        end
        return w;
    endfunction

    function automatic word_t expected_word(input opcode_t op, input word_t a, input word_t b);
        word_t flag;
        flag = '0;
        case (op)
            `OP_NOT, `OP_AND, `OP_OR, `OP_XOR: return tritwise(op, a, b);
            `OP_ADD: return value_word(word_value(a) + word_value(b));
            `OP_SUB: return value_word(word_value(a) - word_value(b));
            `OP_LT: begin
                flag[1:0] = (word_value(a) < word_value(b)) ? `TRIT_POS : `TRIT_ZERO;
                return flag;
            end
            `OP_EQ: begin
                flag[1:0] = (word_value(a) == word_value(b)) ? `TRIT_POS : `TRIT_ZERO;
                return flag;
            end
            // Raw input1, code 10 kept
            default: return a;
        endcase
    endfunction

    // Mirror of the output register
    always @(posedge clock) begin
        if (model_valid) check_count <= check_count + 1;
        if (reset) begin
            model_valid  <= 1'b1;
            expected_out <= '0;
        end else if (alu_enable) begin
            expected_out <= expected_word(opcode, input1, input2);
        end
    end

    a_reset: assert property (@(posedge clock) reset |=> (alu_out == '0))
        else begin
            $error("MISMATCH alu_out after reset: expected %h, got %h", 18'h0, $sampled(alu_out));
            error_count++;
        end

    a_hold: assert property (@(posedge clock)
        (model_valid && !reset && !alu_enable) |=> (alu_out == $past(alu_out)))
        else begin
            $error("MISMATCH alu_out on hold: expected %h, got %h",
                   $past(alu_out), $sampled(alu_out));
            error_count++;
        end

    a_result: assert property (@(posedge clock) model_valid |-> (alu_out == expected_out))
        else begin
            $error("MISMATCH alu_out: expected %h, got %h",
                   $sampled(expected_out), $sampled(alu_out));
            error_count++;
        end

endmodule

// ==== tests/tb_ternary_alu.sv ====
// Ternary ALU testbench with clock, reset, random and directed stimulus and per-test reports
`include "ternary_alu_params.svh"

module tb_ternary_alu;
    timeunit 1ns;
    timeprecision 100ps;
    import ternary_alu_pkg::*;

    // Every trit plus one, every trit minus one
    localparam word_t ALL_POS = 18'h15555;
    localparam word_t ALL_NEG = 18'h3ffff;
    localparam int WAIT_LIMIT = 20;

    logic    clock;
    logic    reset;
    logic    alu_enable;
    opcode_t opcode;
    word_t   input1;
    word_t   input2;
    word_t   alu_out;

    int tests_run;
    int tests_failed;
    int errors_before;

    ternary_alu u_dut (
        .clock      (clock),
        .reset      (reset),
        .alu_enable (alu_enable),
        .opcode     (opcode),
        .input1     (input1),
        .input2     (input2),
        .alu_out    (alu_out)
    );

    bind ternary_alu ternary_alu_props u_props (
        .clock      (clock),
        .reset      (reset),
        .alu_enable (alu_enable),
        .opcode     (opcode),
        .input1     (input1),
        .input2     (input2),
        .alu_out    (alu_out)
    );

    // 40 ns period
    always #20 clock = ~clock;

    // Raw bits, so code 10 shows up too
    function automatic word_t random_word();
        return word_t'($urandom);
    endfunction

    function automatic word_t with_trit(input word_t w, input int pos, input trit_t t);
        word_t r;
        r = w;
        r[pos*`TRIT_BITS +: `TRIT_BITS] = t;
        return r;
    endfunction

    function automatic bit listed_opcode(input opcode_t op);
        case (op)
            `OP_NOT, `OP_AND, `OP_OR, `OP_XOR: return 1'b1;
            `OP_ADD, `OP_SUB, `OP_LT, `OP_EQ:  return 1'b1;
            default:                           return 1'b0;
        endcase
    endfunction

    task automatic apply(input opcode_t op, input word_t a, input word_t b);
        @(posedge clock);
        alu_enable <= 1'b1;
        opcode     <= op;
        input1     <= a;
        input2     <= b;
    endtask

    // Enable low while the operands keep changing
    task automatic stall(input int cycles);
        repeat (cycles) begin
            @(posedge clock);
            alu_enable <= 1'b0;
            input1     <= random_word();
            input2     <= random_word();
        end
    endtask

    task automatic random_ops(input opcode_t op, input int count);
        repeat (count) apply(op, random_word(), random_word());
    endtask

    // Pairs split by trit 8, by trit 0, and one equal pair
    task automatic compare_pairs(input opcode_t op);
        word_t base;
        base = random_word();
        apply(op, with_trit(base, `WORD_TRITS-1, `TRIT_POS),
              with_trit(base, `WORD_TRITS-1, `TRIT_NEG));
        apply(op, with_trit(base, `WORD_TRITS-1, `TRIT_NEG),
              with_trit(base, `WORD_TRITS-1, `TRIT_POS));
        apply(op, with_trit(base, 0, `TRIT_NEG), with_trit(base, 0, `TRIT_ZERO));
        apply(op, with_trit(base, 0, `TRIT_POS), with_trit(base, 0, `TRIT_NEG));
        apply(op, base, base);
    endtask

    // Last item is loaded one edge later and checked on the edge after
    task automatic wait_checks(input string what);
        int target;
        int cycles;
        @(negedge clock);
        target = u_dut.u_props.check_count + 2;
        cycles = 0;
        while (u_dut.u_props.check_count < target) begin
            @(negedge clock);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("timeout waiting for %s", what);
                $display("Done: errors found");
                $finish;
            end
        end
    endtask

    task automatic end_test(input string name);
        int found;
        wait_checks({"checks of test ", name});
        found = u_dut.u_props.error_count - errors_before;
        tests_run++;
        if (found != 0) tests_failed++;
        $display("test %-8s %0d errors", name, found);
        errors_before = u_dut.u_props.error_count;
    endtask

    initial begin
        opcode_t op;
        clock         = 1'b0;
        reset         = 1'b1;
        // Enable high with a nonzero pass-through word during reset
        alu_enable    = 1'b1;
        opcode        = '0;
        input1        = ALL_POS;
        input2        = '0;
        tests_run     = 0;
        tests_failed  = 0;
        errors_before = 0;
        void'($urandom(32'h4004929d));

        // Three cycles in reset
        repeat (3) @(posedge clock);
        reset      <= 1'b0;
        alu_enable <= 1'b0;
        end_test("reset");

        apply(`OP_ADD, random_word(), random_word());
        stall(4);
        end_test("hold");

        random_ops(`OP_NOT, 50);
        random_ops(`OP_AND, 50);
        random_ops(`OP_OR, 50);
        random_ops(`OP_XOR, 50);
        end_test("logic");

        random_ops(`OP_ADD, 50);
        random_ops(`OP_SUB, 50);
        // Extremes that overflow and wrap
        apply(`OP_ADD, ALL_POS, ALL_POS);
        apply(`OP_ADD, ALL_NEG, ALL_NEG);
        apply(`OP_SUB, ALL_POS, ALL_POS);
        apply(`OP_SUB, ALL_NEG, ALL_NEG);
        apply(`OP_SUB, ALL_POS, ALL_NEG);
        apply(`OP_SUB, ALL_NEG, ALL_POS);
        end_test("arith");

        compare_pairs(`OP_LT);
        compare_pairs(`OP_EQ);
        random_ops(`OP_LT, 20);
        random_ops(`OP_EQ, 20);
        end_test("compare");

        apply(6'b10_10_10, random_word(), random_word());
        apply(6'b11_11_11, random_word(), random_word());
        repeat (30) begin
            do begin
                op = opcode_t'($urandom);
            end while (listed_opcode(op));
            apply(op, random_word(), random_word());
        end
        end_test("pass");

        $display("tests run %0d, tests failed %0d, assertion errors %0d",
                 tests_run, tests_failed, u_dut.u_props.error_count);
        if (tests_failed == 0 && u_dut.u_props.error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+hdl
hdl/ternary_alu_pkg.sv
hdl/alu_opcode_decoder.sv
hdl/trit_slice.sv
hdl/alu_result_stage.sv
hdl/ternary_alu.sv
tests/ternary_alu_props.sv
tests/tb_ternary_alu.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the ternary ALU testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert -Wno-fatal -f files.f --top-module tb_ternary_alu \
    --Mdir obj_dir -o tb_ternary_alu > build.log 2>&1 \
    && ./obj_dir/tb_ternary_alu +verilator+error+limit+1000 > sim.log 2>&1

grep -q "Done: no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
